/* hdl/clink_pkg.sv */
package clink_pkg;

    typedef logic [27:0] pixel_word_t;          // One deserialized X channel word
    typedef logic [7:0]  tap_t;                 // One 8-bit pixel tap
    typedef logic [7:0]  uart_byte_t;           // Serial data byte

    typedef logic [4:0]  word_pos_t;            // Bit position inside pixel_word_t
    typedef word_pos_t   tap_map_t [0:7];       // Indexed by tap bit

    localparam int NUM_TAPS = 3;                // Base configuration, X channel only

    //////////////////////////////////////////////////
    // Camera Link X channel bit map
    //////////////////////////////////////////////////

    // Entry n is the word bit that feeds tap bit n
    localparam tap_map_t TAP_MAP_D0 = '{
        5'd6,  5'd5,  5'd4,  5'd3,  5'd2,  5'd1,  5'd27, 5'd26
    };
    localparam tap_map_t TAP_MAP_D1 = '{
        5'd0,  5'd13, 5'd12, 5'd11, 5'd10, 5'd9,  5'd25, 5'd24
    };
    localparam tap_map_t TAP_MAP_D2 = '{
        5'd8,  5'd7,  5'd20, 5'd19, 5'd18, 5'd17, 5'd23, 5'd22
    };

    // Framing bits, bit 21 is spare
    localparam word_pos_t LVAL_POS = 5'd16;
    localparam word_pos_t FVAL_POS = 5'd15;
    localparam word_pos_t DVAL_POS = 5'd14;

    //////////////////////////////////////////////////
    // Serial control link
    //////////////////////////////////////////////////

    // Start + 8 data + stop, no parity
    localparam int UART_FRAME_BITS = 10;

endpackage

/* hdl/clink_video_if.sv */
`timescale 1ns/1ps

interface clink_video_if
    import clink_pkg::*;
();

    tap_t d0;       // Tap A
    tap_t d1;       // Tap B
    tap_t d2;       // Tap C
    logic lval;     // Line valid
    logic fval;     // Frame valid
    logic dval;     // Data valid
    logic valid;    // px_ready one cycle late

    // Unpacker side
    modport source (output d0, d1, d2, lval, fval, dval, valid);

    // Pin register side
    modport sink (input d0, d1, d2, lval, fval, dval, valid);

    // Line detect only
    modport monitor (input lval, valid);

endinterface

/* hdl/clink_port_unpack.sv */
`timescale 1ns/1ps

module clink_port_unpack
    import clink_pkg::*;
(
    input  logic                clink_X_clk_out,
    input  logic                clink_reset_buffer2,
    input  pixel_word_t         pixel_x,        // Deserializer output
    input  logic                px_ready,       // Deserializer lock
    clink_video_if.source       video
);

    //////////////////////////////////////////////////
    // Bit remap
    //////////////////////////////////////////////////

    tap_t taps_next [NUM_TAPS];   // Remapped taps, one per map table

    // Pure wiring, one lookup per tap bit
    always_comb begin
        for (int b = 0; b < $bits(tap_t); b++) begin
            taps_next[0][b] = pixel_x[TAP_MAP_D0[b]];
            taps_next[1][b] = pixel_x[TAP_MAP_D1[b]];
            taps_next[2][b] = pixel_x[TAP_MAP_D2[b]];
        end
    end

    //////////////////////////////////////////////////
    // Word register
    //////////////////////////////////////////////////

    // Tap payload, held while the link is down
    always_ff @(posedge clink_X_clk_out) begin
        if (px_ready) begin
            video.d0 <= taps_next[0];
            video.d1 <= taps_next[1];
            video.d2 <= taps_next[2];
        end
    end

    // Framing and valid level
    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            video.lval  <= 1'b0;
            video.fval  <= 1'b0;
            video.dval  <= 1'b0;
            video.valid <= 1'b0;
        end else begin
            video.valid <= px_ready;                // Lock level, delayed
            if (px_ready) begin
                video.lval <= pixel_x[LVAL_POS];
                video.fval <= pixel_x[FVAL_POS];
                video.dval <= pixel_x[DVAL_POS];
            end
        end
    end

endmodule

/* hdl/clink_ctrl_sync.sv */
`timescale 1ns/1ps

module clink_ctrl_sync (
    input  logic                clink_X_clk_out,
    input  logic                aresetn,        // External, async to pixel clock
    input  logic                auto_start,     // Software arm, async
    clink_video_if.monitor      video,
    output logic                clink_reset_buffer2,
    output logic                line_seen       // Sticky until reset
);

    logic clink_reset_buffer1;
    logic auto_start_buffer1;
    logic auto_start_buffer2;

    // Two-stage synchronizers
    always_ff @(posedge clink_X_clk_out) begin
        clink_reset_buffer1 <= ~aresetn;            // Active high from here on
        clink_reset_buffer2 <= clink_reset_buffer1;
        auto_start_buffer1  <= auto_start;
        auto_start_buffer2  <= auto_start_buffer1;
    end

    // Set on a line while armed
    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            line_seen <= 1'b0;
        end else if (video.valid && video.lval && auto_start_buffer2) begin
            line_seen <= 1'b1;
        end
    end

endmodule

/* hdl/clink_frame_tracker.sv */
`timescale 1ns/1ps

module clink_frame_tracker
    import clink_pkg::*;
(
    input  logic                clink_X_clk_out,
    input  logic                clink_reset_buffer2,
    clink_video_if.sink         video,
    output tap_t                d0,
    output tap_t                d1,
    output tap_t                d2,
    output logic                lval,
    output logic                fval,
    output logic                dval,
    output logic                image_end       // One cycle at frame end
);

    logic fval_prev;    // Output fval, one cycle back

    //////////////////////////////////////////////////
    // Pin registers
    //////////////////////////////////////////////////

    // Taps follow the interface only while locked
    always_ff @(posedge clink_X_clk_out) begin
        if (video.valid) begin
            d0 <= video.d0;
            d1 <= video.d1;
            d2 <= video.d2;
        end
    end

    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            lval <= 1'b0;
            fval <= 1'b0;
            dval <= 1'b0;
        end else if (video.valid) begin
            lval <= video.lval;
            fval <= video.fval;
            dval <= video.dval;
        end
    end

    //////////////////////////////////////////////////
    // Frame end detect
    //////////////////////////////////////////////////

    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            fval_prev <= 1'b0;
        end else begin
            fval_prev <= fval;
        end
    end

    // Falling edge of the pin fval, same cycle
    assign image_end = fval_prev & ~fval;

endmodule

/* hdl/cl_ser_tx.sv */
`timescale 1ns/1ps

module cl_ser_tx
    import clink_pkg::*;
#(
    parameter int CLKS_PER_BIT = 10     // Pixel clocks per serial bit
) (
    input  logic                clink_X_clk_out,
    input  logic                clink_reset_buffer2,
    input  logic                tx_start,       // One-cycle request
    input  uart_byte_t          tx_data,
    output logic                tx_busy,
    output logic                ser_tc          // Serial line to camera
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(UART_FRAME_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(UART_FRAME_BITS - 1);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t                  state;
    logic [CNT_W-1:0]           clk_cnt;        // Position inside the bit
    logic [BIT_W-1:0]           bit_cnt;        // Frame bit on the line
    logic [UART_FRAME_BITS-1:0] frame_sr;       // Stop, data, start; LSB out first

    //////////////////////////////////////////////////
    // FSM and counters
    //////////////////////////////////////////////////

    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (tx_start) state <= TX_SEND;        // Start while busy never seen here
                end
                TX_SEND: begin
                    if (clk_cnt == CNT_LAST) begin
                        clk_cnt <= '0;
                        if (bit_cnt == BIT_LAST) state <= TX_IDLE;  // Stop bit done
                        else bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Frame loaded on accept, shifted at each bit end
    always_ff @(posedge clink_X_clk_out) begin
        if (state == TX_IDLE && tx_start) begin
            frame_sr <= {1'b1, tx_data, 1'b0};
        end else if (state == TX_SEND && clk_cnt == CNT_LAST) begin
            frame_sr <= {1'b1, frame_sr[UART_FRAME_BITS-1:1]};
        end
    end

    assign tx_busy = (state == TX_SEND);
    assign ser_tc  = tx_busy ? frame_sr[0] : 1'b1;  // Idle mark

endmodule

/* hdl/cl_ser_rx.sv */
`timescale 1ns/1ps

module cl_ser_rx
    import clink_pkg::*;
#(
    parameter int CLKS_PER_BIT = 10     // Pixel clocks per serial bit
) (
    input  logic                clink_X_clk_out,
    input  logic                clink_reset_buffer2,
    input  logic                ser_tfg,        // Serial line from camera
    output logic                rx_ready,       // One-cycle byte strobe
    output uart_byte_t          rx_data
);

    localparam int DATA_BITS = UART_FRAME_BITS - 2;    // Less start and stop
    localparam int CNT_W     = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [2:0]       DATA_LAST = 3'(DATA_BITS - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t          state;
    logic               rx_meta;        // First sync stage
    logic               rx_sync;        // Safe to sample
    logic [CNT_W-1:0]   clk_cnt;
    logic [2:0]         bit_idx;
    uart_byte_t         data_sr;        // LSB arrives first

    //////////////////////////////////////////////////
    // Input sync, idles at mark
    //////////////////////////////////////////////////

    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= ser_tfg;
            rx_sync <= rx_meta;
        end
    end

    //////////////////////////////////////////////////
    // Receive FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clink_X_clk_out) begin
        if (clink_reset_buffer2) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= RX_START;       // Falling edge
                end
                RX_START: if (clk_cnt == CNT_HALF) begin
                    clk_cnt <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch rejected
                end
                RX_DATA: if (clk_cnt == CNT_LAST) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == DATA_LAST) state <= RX_STOP;
                end
                RX_STOP: if (clk_cnt == CNT_LAST) begin
                    rx_ready <= rx_sync;                     // Framing error drops byte
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Mid-bit samples and output byte
    always_ff @(posedge clink_X_clk_out) begin
        if (state == RX_DATA && clk_cnt == CNT_LAST) begin
            data_sr <= {rx_sync, data_sr[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && clk_cnt == CNT_LAST && rx_sync) begin
            rx_data <= data_sr;
        end
    end

endmodule

/* hdl/clink_receiver_top.sv */
`timescale 1ns/1ps

module clink_receiver_top
    import clink_pkg::*;
#(
    parameter int CLK_FREQ  = 82_000_000,   // Pixel clock, Hz
    parameter int BAUD_RATE = 9600
) (
    input  logic            clink_X_clk_out,    // Recovered pixel clock
    input  logic            aresetn,
    input  logic            auto_start,         // Master enable

    // X channel word from the deserializer
    input  pixel_word_t     pixel_x,
    input  logic            px_ready,

    // Unpacked video
    output tap_t            d0,
    output tap_t            d1,
    output tap_t            d2,
    output logic            lval,
    output logic            fval,
    output logic            dval,
    output logic            image_end,
    output logic            line_seen,

    // Camera control serial link
    input  logic            tx_start,
    input  uart_byte_t      tx_data,
    output logic            tx_busy,
    output logic            ser_tc,             // SerTC, to camera
    input  logic            ser_tfg,            // SerTFG, from camera
    output logic            rx_ready,
    output uart_byte_t      rx_data
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

    logic clink_reset_buffer2;  // Synchronized reset, active high

    clink_video_if video_if ();

    //////////////////////////////////////////////////
    // Video path
    //////////////////////////////////////////////////

    clink_ctrl_sync ctrl_sync_i (
        .clink_X_clk_out     (clink_X_clk_out),
        .aresetn             (aresetn),
        .auto_start          (auto_start),
        .video               (video_if.monitor),
        .clink_reset_buffer2 (clink_reset_buffer2),
        .line_seen           (line_seen)
    );

    clink_port_unpack port_unpack_i (
        .clink_X_clk_out     (clink_X_clk_out),
        .clink_reset_buffer2 (clink_reset_buffer2),
        .pixel_x             (pixel_x),
        .px_ready            (px_ready),
        .video               (video_if.source)
    );

    clink_frame_tracker frame_tracker_i (
        .clink_X_clk_out     (clink_X_clk_out),
        .clink_reset_buffer2 (clink_reset_buffer2),
        .video               (video_if.sink),
        .d0                  (d0),
        .d1                  (d1),
        .d2                  (d2),
        .lval                (lval),
        .fval                (fval),
        .dval                (dval),
        .image_end           (image_end)
    );

    //////////////////////////////////////////////////
    // Serial link, on the pixel clock
    //////////////////////////////////////////////////

    cl_ser_tx #(
        .CLKS_PER_BIT        (CLKS_PER_BIT)
    ) ser_tx_i (
        .clink_X_clk_out     (clink_X_clk_out),
        .clink_reset_buffer2 (clink_reset_buffer2),
        .tx_start            (tx_start),
        .tx_data             (tx_data),
        .tx_busy             (tx_busy),
        .ser_tc              (ser_tc)
    );

    cl_ser_rx #(
        .CLKS_PER_BIT        (CLKS_PER_BIT)
    ) ser_rx_i (
        .clink_X_clk_out     (clink_X_clk_out),
        .clink_reset_buffer2 (clink_reset_buffer2),
        .ser_tfg             (ser_tfg),
        .rx_ready            (rx_ready),
        .rx_data             (rx_data)
    );

endmodule

/* dv/clink_receiver_properties.sv */
`timescale 1ns/1ps

module clink_receiver_properties (
    input logic clink_X_clk_out,
    input logic clink_reset_buffer2,     // Synchronized reset inside the top
    input logic image_end,
    input logic tx_busy,
    input logic line_seen
);

    // Frame end strobe never stretches
    image_end_single: assert property (
        @(posedge clink_X_clk_out) disable iff (clink_reset_buffer2)
        image_end |=> !image_end
    ) else $error("image_end high for more than one cycle");

    // Transmitter idles once reset has been seen
    tx_idle_in_reset: assert property (
        @(posedge clink_X_clk_out)
        clink_reset_buffer2 |=> !tx_busy
    ) else $error("tx_busy high after a reset cycle");

    // Sticky flag
    line_seen_sticky: assert property (
        @(posedge clink_X_clk_out)
        (line_seen && !clink_reset_buffer2) |=> line_seen
    ) else $error("line_seen fell outside reset");

endmodule

bind clink_receiver_top clink_receiver_properties props_i (.*);

/* dv/clink_receiver_tb.sv */
`timescale 1ns/1ps

module clink_receiver_tb
    import clink_pkg::*;
();

    localparam int CLK_FREQ      = 1_000_000;
    localparam int BAUD_RATE     = 100_000;
    localparam int BIT_CLKS      = CLK_FREQ / BAUD_RATE;
    localparam int FRAME_TIMEOUT = 2 * UART_FRAME_BITS * BIT_CLKS;   // Two frames of slack

    typedef struct {
        pixel_word_t word;
        tap_t        d0, d1, d2;
        logic        lval, fval, dval;
    } vec_t;

    logic        clink_X_clk_out;
    logic        aresetn;
    logic        auto_start;
    pixel_word_t pixel_x;
    logic        px_ready;
    logic        tx_start;
    uart_byte_t  tx_data;
    wire         ser_tfg;
    tap_t        d0, d1, d2;
    logic        lval, fval, dval;
    logic        image_end, line_seen;
    logic        tx_busy, ser_tc;
    logic        rx_ready;
    uart_byte_t  rx_data;

    vec_t        vecs [$];                               // Pixel words and expected pins
    uart_byte_t  tx_bytes [5] = '{8'h55, 8'hA3, 8'h00, 8'hFF, 8'h3C};
    uart_byte_t  rx_byte;
    integer      seed;
    int          rx_count;

    clink_receiver_top #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) dut_i (.*);

    assign ser_tfg = ser_tc;                             // Serial loopback

    initial begin
        clink_X_clk_out = 1'b0;
        forever #5 clink_X_clk_out = ~clink_X_clk_out;
    end

    //////////////////////////////////////////////////
    // Checks and helpers
    //////////////////////////////////////////////////

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_tap(string name, tap_t got, tap_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_byte(string name, uart_byte_t got, uart_byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic add_vec(pixel_word_t w, tap_t a, tap_t b, tap_t c, logic l, logic f, logic d);
        vecs.push_back(vec_t'{w, a, b, c, l, f, d});
    endtask

    // X channel wiring written out bit by bit from the MSB
    function automatic vec_t mapped_vec(pixel_word_t w);
        vec_t v;
        v.word = w;
        v.d0   = {w[26], w[27], w[1], w[2], w[3], w[4], w[5], w[6]};
        v.d1   = {w[24], w[25], w[9], w[10], w[11], w[12], w[13], w[0]};
        v.d2   = {w[22], w[23], w[17], w[18], w[19], w[20], w[7], w[8]};
        v.lval = w[16];
        v.fval = w[15];
        v.dval = w[14];
        return v;
    endfunction

    task automatic apply_reset();
        aresetn = 1'b0;
        repeat (2) @(negedge clink_X_clk_out);
        aresetn = 1'b1;
        repeat (4) @(negedge clink_X_clk_out);          // Two sync stages plus margin
    endtask

    task automatic check_idle();
        check_flag("lval", lval, 1'b0);
        check_flag("fval", fval, 1'b0);
        check_flag("dval", dval, 1'b0);
        check_flag("image_end", image_end, 1'b0);
        check_flag("line_seen", line_seen, 1'b0);
        check_flag("tx_busy", tx_busy, 1'b0);
        check_flag("rx_ready", rx_ready, 1'b0);
        check_flag("ser_tc", ser_tc, 1'b1);             // Idle mark
    endtask

    task automatic wait_tx_idle();
        int cycles;
        cycles = 0;
        while (tx_busy !== 1'b0) begin
            if (cycles == FRAME_TIMEOUT) abort_run("tx_busy stayed high past a frame time");
            @(negedge clink_X_clk_out);
            cycles++;
        end
    endtask

    task automatic wait_line_seen();
        int cycles;
        cycles = 0;
        while (line_seen !== 1'b1) begin
            if (cycles == 8) abort_run("line_seen did not rise after an armed line");
            @(negedge clink_X_clk_out);
            cycles++;
        end
    endtask

    task automatic wait_rx_byte(output uart_byte_t b);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clink_X_clk_out);
            cycles++;
            if (cycles > FRAME_TIMEOUT) abort_run("no byte on rx_ready before the timeout");
        end while (rx_ready !== 1'b1);
        b = rx_data;
    endtask

    task automatic send_byte(uart_byte_t b);
        @(negedge clink_X_clk_out);
        tx_start = 1'b1;
        tx_data  = b;
        @(negedge clink_X_clk_out);
        tx_start = 1'b0;
    endtask

    // One word per cycle with pins checked two clocks behind
    task automatic stream_vecs();
        logic prev_fval;
        int   n;
        prev_fval = 1'b0;                                // Pins idle after reset
        n = vecs.size();
        for (int i = 0; i < n + 2; i++) begin
            @(negedge clink_X_clk_out);
            if (i >= 2) begin
                check_tap("d0", d0, vecs[i-2].d0);
                check_tap("d1", d1, vecs[i-2].d1);
                check_tap("d2", d2, vecs[i-2].d2);
                check_flag("lval", lval, vecs[i-2].lval);
                check_flag("fval", fval, vecs[i-2].fval);
                check_flag("dval", dval, vecs[i-2].dval);
                check_flag("image_end", image_end, prev_fval & ~vecs[i-2].fval);
                check_flag("line_seen", line_seen, 1'b0);  // Not armed yet
                prev_fval = vecs[i-2].fval;
            end
            px_ready = (i < n);
            if (i < n) pixel_x = vecs[i].word;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        aresetn    = 1'b0;
        auto_start = 1'b0;
        pixel_x    = '0;
        px_ready   = 1'b0;
        tx_start   = 1'b0;
        tx_data    = '0;
        seed       = 32'h0761_3f69;

        apply_reset();
        check_idle();

        // Word, d0, d1, d2, lval, fval, dval
        add_vec(28'h0000000, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);
        add_vec(28'hFFFFFFF, 8'hFF, 8'hFF, 8'hFF, 1'b1, 1'b1, 1'b1);
        add_vec(28'h0000040, 8'h01, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);  // Frame end here
        add_vec(28'h8000000, 8'h40, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);
        add_vec(28'h0000001, 8'h00, 8'h01, 8'h00, 1'b0, 1'b0, 1'b0);
        add_vec(28'h1000000, 8'h00, 8'h80, 8'h00, 1'b0, 1'b0, 1'b0);
        add_vec(28'h0000100, 8'h00, 8'h00, 8'h01, 1'b0, 1'b0, 1'b0);
        add_vec(28'h0400000, 8'h00, 8'h00, 8'h80, 1'b0, 1'b0, 1'b0);
        add_vec(28'h0010000, 8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);  // Line while disarmed
        add_vec(28'h0008000, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        add_vec(28'h0004000, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1);  // Second frame end
        add_vec(28'h0200000, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);  // Spare bit only
        add_vec(28'h0003E7E, 8'h3F, 8'h3E, 8'h00, 1'b0, 1'b0, 1'b0);
        add_vec(28'h01F0000, 8'h00, 8'h00, 8'h3C, 1'b1, 1'b0, 1'b0);
        repeat (24) vecs.push_back(mapped_vec(pixel_word_t'($random(seed))));
        add_vec(28'h0010000, 8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);  // Leaves lval held
        stream_vecs();

        // Arm and send a single line word
        auto_start = 1'b1;
        repeat (3) @(negedge clink_X_clk_out);
        check_flag("line_seen", line_seen, 1'b0);       // Line held without valid
        pixel_x  = 28'h0010000;
        px_ready = 1'b1;
        @(negedge clink_X_clk_out);
        px_ready = 1'b0;
        wait_line_seen();
        auto_start = 1'b0;
        pixel_x    = '0;
        px_ready   = 1'b1;
        repeat (8) begin
            @(negedge clink_X_clk_out);
            check_flag("line_seen", line_seen, 1'b1);   // Held while disarmed
        end
        px_ready = 1'b0;

        // Loopback bytes
        foreach (tx_bytes[k]) begin
            wait_tx_idle();
            send_byte(tx_bytes[k]);
            check_flag("tx_busy", tx_busy, 1'b1);
            wait_rx_byte(rx_byte);
            check_byte("rx_data", rx_byte, tx_bytes[k]);
        end
        wait_tx_idle();

        // Second strobe mid frame is dropped
        send_byte(8'h96);
        repeat (15) @(negedge clink_X_clk_out);
        check_flag("tx_busy", tx_busy, 1'b1);
        send_byte(8'h69);
        rx_count = 0;
        repeat (3 * UART_FRAME_BITS * BIT_CLKS) begin
            @(negedge clink_X_clk_out);
            if (rx_ready === 1'b1) begin
                rx_count++;
                check_byte("rx_data", rx_data, 8'h96);
            end
        end
        if (rx_count != 1) begin
            abort_run($sformatf("a strobe while busy gave %0d received bytes instead of one",
                                rx_count));
        end
        check_flag("tx_busy", tx_busy, 1'b0);

        // Only reset clears the sticky flag
        apply_reset();
        check_idle();

        $display("Done: no errors");
        $finish;
    end

endmodule

/* filelist.f */
hdl/clink_pkg.sv
hdl/clink_video_if.sv
hdl/clink_port_unpack.sv
hdl/clink_ctrl_sync.sv
hdl/clink_frame_tracker.sv
hdl/cl_ser_tx.sv
hdl/cl_ser_rx.sv
hdl/clink_receiver_top.sv
dv/clink_receiver_properties.sv
dv/clink_receiver_tb.sv
